// File: common/premem_pkg.sv
package premem_pkg;

    //////////////////////////////////////////////////
    // widths fixed by the instruction set
    //////////////////////////////////////////////////
    localparam int WORD_W       = 32;
    localparam int GPR_W        = 5;   // register number
    localparam int CL_W         = 5;   // clo/clz count
    localparam int DATA_INDEX_W = 12;
    localparam int STRB_W       = 4;
    localparam int SIZE_W       = 2;
    localparam int ALIGN_W      = 2;
    localparam int LOAD_SEL_W   = 3;

    // one-hot select of the arithmetic result source
    localparam int MATH_SEL_W = 4;
    localparam int MATH_ALU   = 0;
    localparam int MATH_MULR  = 1;
    localparam int MATH_CL    = 2;
    localparam int MATH_MDU   = 3;

    // one-hot tlb operation
    localparam int TLB_OP_W     = 4;
    localparam int TLB_OP_TLBP  = 0;   // probe
    localparam int TLB_OP_TLBR  = 1;   // read
    localparam int TLB_OP_TLBWI = 2;   // write indexed
    localparam int TLB_OP_TLBWR = 3;   // write random

    // bus size codes (no code 2)
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd3;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [GPR_W-1:0]      write_num;  // 0 means no writeback
        logic [WORD_W-1:0]     alu_res;    // also the memory address
        logic [WORD_W-1:0]     mdu_res;
        logic [WORD_W-1:0]     mul_res;
        logic [WORD_W-1:0]     store_data;
        logic [CL_W-1:0]       cl_res;
        logic [MATH_SEL_W-1:0] math_sel;
        logic                  mem_req;
        logic                  mem_wr;
        logic                  mem_atom;   // ll / sc
        logic [STRB_W-1:0]     mem_strb;
        logic [LOAD_SEL_W-1:0] load_sel;
        logic                  is_tlb;
        logic [TLB_OP_W-1:0]   tlb_op;
        logic                  eret;
    } exe_payload_t;

    typedef struct packed {
        logic                    req;
        logic                    wr;
        logic [DATA_INDEX_W-1:0] index;
        logic [SIZE_W-1:0]       size;
        logic [STRB_W-1:0]       wstrb;
        logic [WORD_W-1:0]       wdata;
    } data_bus_t;

    typedef struct packed {
        logic              search;
        logic              read;
        logic              write_index;
        logic              write_random;
        logic              map;
        logic [WORD_W-1:0] vaddr;
    } tlb_cmd_t;

    typedef struct packed {
        logic [GPR_W-1:0]      write_num;
        logic [LOAD_SEL_W-1:0] load_sel;
        logic                  mem_req;
        logic [ALIGN_W-1:0]    align;      // low address bits for the align check
        logic [WORD_W-1:0]     prelim_res;
        logic [WORD_W-1:0]     rt_data;
    } premem_out_t;

endpackage

// File: source/stage_reg.sv
`timescale 1ns/1ns

module stage_reg (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  premem_pkg::exe_payload_t exe_payload_i,
    input  logic                     exe_valid_i,
    input  logic                     sba_allowin_i,
    input  logic                     sba_flush_i,
    input  logic                     mem_allowin_i,
    input  logic                     exc_flush_i,
    input  logic                     ready_i,
    output premem_pkg::exe_payload_t payload_o,
    output logic                     has_data_o,
    output logic                     allowin_o,
    output logic                     valid_o
);

    premem_pkg::exe_payload_t payload_q;
    logic                     has_data_q;
    logic                     pre_valid;  // incoming item survives the flush
    logic                     move;
    logic                     load;
    logic                     clear;

    //////////////////////////////////////////////////
    // interlock
    //////////////////////////////////////////////////
    assign pre_valid = exe_valid_i && !sba_flush_i;

    // empty, or the held item can leave this cycle
    assign allowin_o = !has_data_q || (ready_i && mem_allowin_i);
    assign move      = allowin_o && sba_allowin_i;

    assign load  = move && pre_valid;
    assign clear = (move && !pre_valid) || exc_flush_i;  // exception wins over load

    assign valid_o = has_data_q && ready_i && sba_allowin_i;

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    // cleared payload keeps write_num at 0 so no false hazard is seen
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            payload_q <= '0;
        end else if (clear) begin
            payload_q <= '0;
        end else if (load) begin
            payload_q <= exe_payload_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            has_data_q <= 1'b0;
        end else if (clear) begin
            has_data_q <= 1'b0;
        end else if (load) begin
            has_data_q <= 1'b1;
        end
    end

    assign payload_o  = payload_q;
    assign has_data_o = has_data_q;

endmodule

// File: source/access_issue.sv
`timescale 1ns/1ns

module access_issue (
    input  premem_pkg::exe_payload_t payload_i,
    input  logic                     has_data_i,
    input  logic                     mem_risk_i,
    input  logic                     mem_allowin_i,
    input  logic                     data_index_ok_i,
    output premem_pkg::data_bus_t    data_bus_o,
    output premem_pkg::tlb_cmd_t     tlb_cmd_o,
    output logic                     ready_o
);

    logic                          mem_item;   // held memory access
    logic                          tlb_item;   // held tlb instruction
    logic                          mem_stall;
    logic                          tlb_stall;
    logic                          tlb_ok;
    logic [2:0]                    strb_cnt;
    logic [premem_pkg::SIZE_W-1:0] size;

    assign mem_item = has_data_i && payload_i.mem_req;
    assign tlb_item = has_data_i && payload_i.is_tlb;

    //////////////////////////////////////////////////
    // stall decision
    //////////////////////////////////////////////////
    // memory ops wait for the mem stage hazard to clear and for the cache
    // to take the index
    assign mem_stall = mem_item && (mem_risk_i || !data_index_ok_i);
    assign tlb_stall = tlb_item && mem_risk_i;  // tlb must see a drained pipe

    assign ready_o = !(mem_stall || tlb_stall);

    //////////////////////////////////////////////////
    // data cache first step
    //////////////////////////////////////////////////
    // number of enabled byte lanes
    always_comb begin
        strb_cnt = '0;
        for (int i = 0; i < premem_pkg::STRB_W; i++) begin
            strb_cnt = strb_cnt + 3'(payload_i.mem_strb[i]);
        end
    end

    always_comb begin
        case (strb_cnt)
            3'd1:    size = premem_pkg::SIZE_BYTE;
            3'd2:    size = premem_pkg::SIZE_HALF;
            default: size = premem_pkg::SIZE_WORD;   // loads have no strobes
        endcase
    end

    assign data_bus_o.req   = mem_item && !mem_risk_i && mem_allowin_i;
    assign data_bus_o.wr    = has_data_i && payload_i.mem_wr;
    assign data_bus_o.index = payload_i.alu_res[premem_pkg::DATA_INDEX_W-1:0];
    assign data_bus_o.size  = size;
    assign data_bus_o.wstrb = has_data_i ? payload_i.mem_strb : '0;
    assign data_bus_o.wdata = payload_i.store_data;

    //////////////////////////////////////////////////
    // tlb strobes
    //////////////////////////////////////////////////
    assign tlb_ok = tlb_item && !mem_risk_i;

    assign tlb_cmd_o.search       = tlb_ok && payload_i.tlb_op[premem_pkg::TLB_OP_TLBP];
    assign tlb_cmd_o.read         = tlb_ok && payload_i.tlb_op[premem_pkg::TLB_OP_TLBR];
    assign tlb_cmd_o.write_index  = tlb_ok && payload_i.tlb_op[premem_pkg::TLB_OP_TLBWI];
    assign tlb_cmd_o.write_random = tlb_ok && payload_i.tlb_op[premem_pkg::TLB_OP_TLBWR];

    // address translation for the data access
    assign tlb_cmd_o.map   = mem_item && !mem_risk_i;
    assign tlb_cmd_o.vaddr = payload_i.alu_res;

endmodule

// File: source/result_select.sv
`timescale 1ns/1ns

module result_select (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  premem_pkg::exe_payload_t      payload_i,
    input  logic                          has_data_i,
    output logic [premem_pkg::WORD_W-1:0] prelim_res_o
);

    logic                          is_ll;
    logic                          is_sc;
    logic                          ll_bit;
    logic [premem_pkg::WORD_W-1:0] cl_ext;

    //////////////////////////////////////////////////
    // load linked bit
    //////////////////////////////////////////////////
    assign is_ll = has_data_i && payload_i.mem_req && !payload_i.mem_wr && payload_i.mem_atom;
    assign is_sc = has_data_i && payload_i.mem_req && payload_i.mem_wr && payload_i.mem_atom;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ll_bit <= 1'b0;
        end else if (has_data_i && payload_i.eret) begin
            ll_bit <= 1'b0;   // eret breaks the link
        end else if (is_ll) begin
            ll_bit <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // preliminary result
    //////////////////////////////////////////////////
    assign cl_ext = {{(premem_pkg::WORD_W - premem_pkg::CL_W){1'b0}}, payload_i.cl_res};

    always_comb begin
        prelim_res_o = '0;
        if (payload_i.math_sel[premem_pkg::MATH_ALU]) begin
            prelim_res_o = prelim_res_o | payload_i.alu_res;
        end
        if (payload_i.math_sel[premem_pkg::MATH_MULR]) begin
            prelim_res_o = prelim_res_o | payload_i.mul_res;
        end
        if (payload_i.math_sel[premem_pkg::MATH_CL]) begin
            prelim_res_o = prelim_res_o | cl_ext;
        end
        if (payload_i.math_sel[premem_pkg::MATH_MDU]) begin
            prelim_res_o = prelim_res_o | payload_i.mdu_res;
        end
        // sc writes back its success flag
        prelim_res_o[0] = prelim_res_o[0] | (is_sc && ll_bit);
    end

endmodule

// File: source/premem_top.sv
`timescale 1ns/1ns

module premem_top (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // from execute
    input  premem_pkg::exe_payload_t exe_payload_i,
    input  logic                     exe_valid_i,

    // interlock and flush
    input  logic                     sba_allowin_i,
    input  logic                     sba_flush_i,
    input  logic                     mem_allowin_i,
    input  logic                     mem_risk_i,
    input  logic                     exc_flush_i,

    // cache handshake level
    input  logic                     data_index_ok_i,

    output logic                     premem_allowin_o,
    output logic                     premem_valid_o,
    output premem_pkg::premem_out_t  premem_out_o,
    output premem_pkg::data_bus_t    data_bus_o,
    output premem_pkg::tlb_cmd_t     tlb_cmd_o,
    output logic [premem_pkg::GPR_W-1:0] write_num_w_o
);

    premem_pkg::exe_payload_t         payload;
    logic                             has_data;
    logic                             ready;
    logic [premem_pkg::WORD_W-1:0]    prelim_res;

    //////////////////////////////////////////////////
    // stage register and interlock
    //////////////////////////////////////////////////
    stage_reg u_stage_reg (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .exe_payload_i  (exe_payload_i),
        .exe_valid_i    (exe_valid_i),
        .sba_allowin_i  (sba_allowin_i),
        .sba_flush_i    (sba_flush_i),
        .mem_allowin_i  (mem_allowin_i),
        .exc_flush_i    (exc_flush_i),
        .ready_i        (ready),
        .payload_o      (payload),
        .has_data_o     (has_data),
        .allowin_o      (premem_allowin_o),
        .valid_o        (premem_valid_o)
    );

    //////////////////////////////////////////////////
    // cache and tlb first step
    //////////////////////////////////////////////////
    access_issue u_access_issue (
        .payload_i       (payload),
        .has_data_i      (has_data),
        .mem_risk_i      (mem_risk_i),
        .mem_allowin_i   (mem_allowin_i),
        .data_index_ok_i (data_index_ok_i),
        .data_bus_o      (data_bus_o),
        .tlb_cmd_o       (tlb_cmd_o),
        .ready_o         (ready)
    );

    //////////////////////////////////////////////////
    // ll bit and preliminary result
    //////////////////////////////////////////////////
    result_select u_result_select (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .payload_i    (payload),
        .has_data_i   (has_data),
        .prelim_res_o (prelim_res)
    );

    // bundle for the next stage
    assign premem_out_o.write_num  = payload.write_num;
    assign premem_out_o.load_sel   = payload.load_sel;
    assign premem_out_o.mem_req    = payload.mem_req;
    assign premem_out_o.align      = payload.alu_res[premem_pkg::ALIGN_W-1:0];
    assign premem_out_o.prelim_res = prelim_res;
    assign premem_out_o.rt_data    = payload.store_data;  // same word as the bus wdata

    assign write_num_w_o = payload.write_num;  // for hazard detection in decode

endmodule

// File: dv/premem_tb.sv
`timescale 1ns/1ns

module premem_tb;

    localparam int          NROW = 31;
    localparam int          NFLD = 8;             // words per pattern row
    localparam logic [31:0] NONE = 32'h0000_00ff; // no held item to compare
    localparam logic [31:0] SEED = 32'hb2a3_015d;

    logic                                clk;
    logic                                arst_n_i;
    premem_pkg::exe_payload_t            exe_payload_i;
    logic                                exe_valid_i;
    logic                                sba_allowin_i;
    logic                                sba_flush_i;
    logic                                mem_allowin_i;
    logic                                mem_risk_i;
    logic                                exc_flush_i;
    logic                                data_index_ok_i;
    logic                                premem_allowin_o;
    logic                                premem_valid_o;
    premem_pkg::premem_out_t             premem_out_o;
    premem_pkg::data_bus_t               data_bus_o;
    premem_pkg::tlb_cmd_t                tlb_cmd_o;
    logic [premem_pkg::GPR_W-1:0]        write_num_w_o;

    logic [31:0] vec [0:NROW*NFLD-1];
    logic [31:0] sd [0:NROW-1];       // store data driven per row
    logic [31:0] rng;
    logic [31:0] cur_id;
    logic        aborted;
    int          cur_row;
    int          errors;
    int          checks;
    int          tests;
    int          test_err;
    int          n;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    premem_top dut0 (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .exe_payload_i    (exe_payload_i),
        .exe_valid_i      (exe_valid_i),
        .sba_allowin_i    (sba_allowin_i),
        .sba_flush_i      (sba_flush_i),
        .mem_allowin_i    (mem_allowin_i),
        .mem_risk_i       (mem_risk_i),
        .exc_flush_i      (exc_flush_i),
        .data_index_ok_i  (data_index_ok_i),
        .premem_allowin_o (premem_allowin_o),
        .premem_valid_o   (premem_valid_o),
        .premem_out_o     (premem_out_o),
        .data_bus_o       (data_bus_o),
        .tlb_cmd_o        (tlb_cmd_o),
        .write_num_w_o    (write_num_w_o)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL row %0d %s got %h expected %h", cur_row, name, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic finish_test();
        tests++;
        if (test_err == 0) begin
            $display("test %0d ok", cur_id);
        end else begin
            $display("test %0d failed with %0d errors", cur_id, test_err);
        end
        test_err = 0;
    endtask

    // outputs that must stay quiet in and right after reset
    task automatic check_reset_outputs();
        check_val("premem_allowin_o", 32'(premem_allowin_o), 32'd1);
        check_val("premem_valid_o", 32'(premem_valid_o), 32'd0);
        check_val("data_bus_o.req", 32'(data_bus_o.req), 32'd0);
        check_val("tlb_cmd_o.search", 32'(tlb_cmd_o.search), 32'd0);
        check_val("tlb_cmd_o.read", 32'(tlb_cmd_o.read), 32'd0);
        check_val("tlb_cmd_o.write_index", 32'(tlb_cmd_o.write_index), 32'd0);
        check_val("tlb_cmd_o.write_random", 32'(tlb_cmd_o.write_random), 32'd0);
        check_val("tlb_cmd_o.map", 32'(tlb_cmd_o.map), 32'd0);
    endtask

    task automatic drive_row(input int r);
        logic [31:0] c;
        logic [31:0] p;
        logic [31:0] other;
        c     = vec[r*NFLD+1];
        p     = vec[r*NFLD+2];
        other = vec[r*NFLD+4];
        exe_valid_i     = c[0];
        sba_allowin_i   = c[1];
        sba_flush_i     = c[2];
        mem_allowin_i   = c[3];
        mem_risk_i      = c[4];
        data_index_ok_i = c[5];
        exc_flush_i     = c[6];
        exe_payload_i.write_num = p[4:0];
        exe_payload_i.math_sel  = p[8:5];
        exe_payload_i.mem_req   = p[9];
        exe_payload_i.mem_wr    = p[10];
        exe_payload_i.mem_atom  = p[11];
        exe_payload_i.mem_strb  = p[15:12];
        exe_payload_i.load_sel  = p[18:16];
        exe_payload_i.is_tlb    = p[19];
        exe_payload_i.tlb_op    = p[23:20];
        exe_payload_i.eret      = p[24];
        exe_payload_i.cl_res    = p[29:25];
        exe_payload_i.alu_res   = vec[r*NFLD+3];
        rng = xorshift(rng);
        sd[r] = rng;
        exe_payload_i.store_data = rng;
        rng = xorshift(rng);
        exe_payload_i.mul_res = p[6] ? other : rng;  // random unless selected
        rng = xorshift(rng);
        exe_payload_i.mdu_res = p[8] ? other : rng;
    endtask

    task automatic check_row(input int r);
        logic [31:0] f;
        logic [31:0] src;
        logic [31:0] sp;
        logic [31:0] a;
        int          s;
        f   = vec[r*NFLD+5];
        src = vec[r*NFLD+7];
        check_val("premem_allowin_o", 32'(premem_allowin_o), 32'(f[0]));
        check_val("premem_valid_o", 32'(premem_valid_o), 32'(f[1]));
        check_val("data_bus_o.req", 32'(data_bus_o.req), 32'(f[2]));
        check_val("data_bus_o.wr", 32'(data_bus_o.wr), 32'(f[3]));
        check_val("data_bus_o.size", 32'(data_bus_o.size), 32'(f[5:4]));
        check_val("tlb_cmd_o.search", 32'(tlb_cmd_o.search), 32'(f[6]));
        check_val("tlb_cmd_o.read", 32'(tlb_cmd_o.read), 32'(f[7]));
        check_val("tlb_cmd_o.write_index", 32'(tlb_cmd_o.write_index), 32'(f[8]));
        check_val("tlb_cmd_o.write_random", 32'(tlb_cmd_o.write_random), 32'(f[9]));
        check_val("tlb_cmd_o.map", 32'(tlb_cmd_o.map), 32'(f[10]));
        check_val("premem_out_o.prelim_res", premem_out_o.prelim_res, vec[r*NFLD+6]);
        if (src == NONE) begin
            // empty stage
            check_val("write_num_w_o", 32'(write_num_w_o), 32'd0);
            check_val("premem_out_o.write_num", 32'(premem_out_o.write_num), 32'd0);
            check_val("data_bus_o.wstrb", 32'(data_bus_o.wstrb), 32'd0);
        end else begin
            s  = int'(src[7:0]);
            sp = vec[s*NFLD+2];
            a  = vec[s*NFLD+3];
            check_val("write_num_w_o", 32'(write_num_w_o), 32'(sp[4:0]));
            check_val("premem_out_o.write_num", 32'(premem_out_o.write_num), 32'(sp[4:0]));
            check_val("data_bus_o.wstrb", 32'(data_bus_o.wstrb), 32'(sp[15:12]));
            check_val("data_bus_o.index", 32'(data_bus_o.index), 32'(a[11:0]));
            check_val("data_bus_o.wdata", data_bus_o.wdata, sd[s]);
            check_val("premem_out_o.rt_data", premem_out_o.rt_data, sd[s]);
            check_val("tlb_cmd_o.vaddr", tlb_cmd_o.vaddr, a);
            check_val("premem_out_o.align", 32'(premem_out_o.align), 32'(a[1:0]));
            check_val("premem_out_o.load_sel", 32'(premem_out_o.load_sel), 32'(sp[18:16]));
            check_val("premem_out_o.mem_req", 32'(premem_out_o.mem_req), 32'(sp[9]));
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        arst_n_i        = 1'b0;
        exe_payload_i   = '0;
        exe_valid_i     = 1'b0;
        sba_allowin_i   = 1'b0;
        sba_flush_i     = 1'b0;
        mem_allowin_i   = 1'b0;
        mem_risk_i      = 1'b0;
        exc_flush_i     = 1'b0;
        data_index_ok_i = 1'b0;
        rng      = SEED;
        cur_id   = 32'd1;
        cur_row  = -1;
        aborted  = 1'b0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        test_err = 0;
        $readmemh("dv/premem_patterns.txt", vec);

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #2;
            check_reset_outputs();
        end
        @(negedge clk);
        arst_n_i = 1'b1;

        n = 0;
        while (premem_allowin_o !== 1'b1 && n < 8) begin
            @(posedge clk);
            n++;
        end

        if (vec[0] === 32'hx || vec[(NROW-1)*NFLD+7] === 32'hx) begin
            $display("pattern file is missing or too short");
            aborted = 1'b1;
        end else if (premem_allowin_o !== 1'b1) begin
            $display("timeout while waiting for allow-in after reset");
            aborted = 1'b1;
        end else begin
            check_reset_outputs();

            // one row per cycle with the check 2 ns before the rising edge
            for (int r = 0; r < NROW; r++) begin
                @(negedge clk);
                if (vec[r*NFLD] !== cur_id) begin
                    finish_test();
                    cur_id = vec[r*NFLD];
                end
                drive_row(r);
                #8;
                cur_row = r;
                check_row(r);
            end
            finish_test();
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/premem_pkg.sv
source/stage_reg.sv
source/access_issue.sv
source/result_select.sv
source/premem_top.sv
dv/premem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pre-memory stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module premem_tb -o premem_sim &&
out="$(./obj_dir/premem_sim)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation or build failed"; exit 1; }

// File: dv/premem_patterns.txt
// id ctrl pctl alu other exp_flags exp_prelim src_row (all hex, src ff = stage empty)
// ctrl: valid,sba_allowin,sba_flush,mem_allowin,mem_risk,index_ok,exc_flush from bit 0
// pctl: wnum[4:0] msel[8:5] req wr atom strb[15:12] lsel[18:16] tlb op[23:20] eret cl[29:25]
// flags: allowin valid req wr size[5:4] search read wr_idx wr_rand map from bit 0
// reset idle
1 2a 0 0 0 31 0 ff
// stores, half then byte
2 2b 3620 12345678 0 31 0 ff
2 2a 0 0 0 41f 12345678 1
2 2b 4620 abc 0 31 0 ff
2 2a 0 0 0 40f abc 3
// back-pressure and index stall
3 2b 30225 1004 0 31 0 ff
3 23 20 deadbeef 0 432 1004 5
3 23 20 deadbeef 0 432 1004 5
3 0b 20 deadbeef 0 434 1004 5
3 2a 0 0 0 437 1004 5
// tlb strobes
4 2b 180000 80000000 0 31 0 ff
4 2b 280000 80000004 0 73 0 a
4 2b 480000 80000008 0 b3 0 b
4 2b 880000 8000000c 0 133 0 c
4 3a 0 0 0 30 0 d
4 2a 0 0 0 233 0 d
// result select and ll / sc
5 2b 41 11111111 cafe0001 31 0 ff
5 2b 3e000082 22222222 0 33 cafe0001 10
5 2b 103 33333333 0badf00d 33 1f 11
5 2b fe04 2000 0 33 0badf00d 12
5 2b a04 2000 0 43f 0 13
5 2b fe04 2000 0 437 0 14
5 2b 1000000 0 0 43f 1 15
5 2b fe04 2000 0 33 0 16
5 2a 0 0 0 43f 0 17
// flushes
6 2f 21 55 0 31 0 ff
6 2a 0 0 0 31 0 ff
6 2b 21 66 0 31 0 ff
6 6a 0 0 0 33 66 1b
6 6b 21 77 0 31 0 ff
6 2a 0 0 0 31 0 ff
